// File: verilog/dcache_front_pkg.sv
// ================================================
// Shared sizes, source ids and the prefetcher
// parameter word for the data-cache front end
// ================================================
`default_nettype none

package dcache_front_pkg;

  localparam int NR_HWPF  = 4;
  localparam int NR_REQ   = 6;  // load, store, then the engines
  localparam int NR_SNOOP = 2;  // load and store ports

  localparam int SID_W = 3;
  localparam logic [SID_W-1:0] SID_LOAD  = 3'd0;
  localparam logic [SID_W-1:0] SID_STORE = 3'd1;
  localparam logic [SID_W-1:0] SID_HWPF0 = 3'd2;  // engine h uses SID_HWPF0 + h

  localparam int ADDR_W     = 64;
  localparam int WORD_W     = 64;
  localparam int LINE_OFS_W = 6;  // 64-byte lines

  // throttle word, low bits only
  localparam int NWAIT_W = 16;

  // status word layout: enables at bit 0, busy bits from here
  localparam int STATUS_BUSY_LSB = 16;

  localparam int STRIDE_W = 32;
  localparam int NLINES_W = 16;

  // field view of the prefetcher parameter word
  typedef struct packed {
    logic [WORD_W-STRIDE_W-NLINES_W-1:0] rsvd;
    logic [NLINES_W-1:0]                 nlines;  // lines per burst
    logic [STRIDE_W-1:0]                 stride;  // bytes
  } hwpf_param_fields_t;

  // software sees the raw word, the engine reads fields
  typedef union packed {
    logic [WORD_W-1:0]  raw;
    hwpf_param_fields_t f;
  } hwpf_param_u;

endpackage

`default_nettype wire

// File: verilog/hwpf_stride_engine.sv
// ================================================
// One stride prefetcher: config registers, snoop
// trigger, address stepping and request throttle
// ================================================
`timescale 1ns/10ps
`default_nettype none

module hwpf_stride_engine
  import dcache_front_pkg::*;
(
  input  logic                             clk_i,
  input  logic                             rst_ni,

  input  logic                             base_set_i,
  input  logic                             param_set_i,
  input  logic                             throttle_set_i,
  input  logic [WORD_W-1:0]                base_i,
  input  logic [WORD_W-1:0]                param_i,
  input  logic [WORD_W-1:0]                throttle_i,
  output logic [WORD_W-1:0]                base_o,
  output hwpf_param_u                      param_o,
  output logic [WORD_W-1:0]                throttle_o,

  input  logic [NR_SNOOP-1:0]              snoop_valid_i,
  input  logic [NR_SNOOP-1:0][ADDR_W-1:0]  snoop_addr_i,

  output logic                             enable_o,
  output logic                             busy_o,

  output logic                             req_valid_o,
  output logic [ADDR_W-1:0]                req_addr_o,
  input  logic                             req_ready_i
);

  logic [WORD_W-1:0]   base_q;
  hwpf_param_u         param_q;
  logic [WORD_W-1:0]   throttle_q;

  logic                busy_q;
  logic                valid_q;
  logic [ADDR_W-1:0]   addr_q;
  logic [NLINES_W-1:0] rem_q;   // requests still to be accepted
  logic [NWAIT_W-1:0]  wait_q;

  logic [ADDR_W-1:0]   base_line;
  logic [ADDR_W-1:0]   stride;
  logic [NWAIT_W-1:0]  nwait;
  logic                snoop_hit;
  logic                trigger;
  logic                accept;

  assign base_line = {base_q[WORD_W-1:LINE_OFS_W], {LINE_OFS_W{1'b0}}};
  assign stride    = ADDR_W'(param_q.f.stride);
  assign nwait     = throttle_q[NWAIT_W-1:0];

  // line compare only, offset bits ignored
  always_comb begin
    snoop_hit = 1'b0;
    for (int p = 0; p < NR_SNOOP; p++) begin
      if (snoop_valid_i[p] &&
          snoop_addr_i[p][ADDR_W-1:LINE_OFS_W] == base_q[WORD_W-1:LINE_OFS_W]) begin
        snoop_hit = 1'b1;
      end
    end
  end

  assign trigger = base_q[0] && !busy_q && (param_q.f.nlines != '0) && snoop_hit;
  assign accept  = valid_q && req_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      base_q     <= '0;
      param_q    <= '0;
      throttle_q <= '0;
      busy_q     <= 1'b0;
      valid_q    <= 1'b0;
      addr_q     <= '0;
      rem_q      <= '0;
      wait_q     <= '0;
    end else begin
      if (param_set_i) param_q.raw <= param_i;
      if (throttle_set_i) throttle_q <= throttle_i;

      if (base_set_i) begin
        // new base kills any running burst
        base_q  <= base_i;
        busy_q  <= 1'b0;
        valid_q <= 1'b0;
      end else if (trigger) begin
        busy_q  <= 1'b1;
        valid_q <= 1'b1;
        addr_q  <= base_line + stride;
        rem_q   <= param_q.f.nlines;  // snapshot burst length
      end else if (accept) begin
        valid_q <= 1'b0;
        if (rem_q == NLINES_W'(1)) begin
          // burst done, base moves to the last line fetched
          busy_q <= 1'b0;
          base_q <= {addr_q[ADDR_W-1:LINE_OFS_W], base_q[LINE_OFS_W-1:0]};
        end else begin
          addr_q <= addr_q + stride;
          rem_q  <= rem_q - 1'b1;
          wait_q <= nwait;
        end
      end else if (busy_q && !valid_q) begin
        if (wait_q == '0) valid_q <= 1'b1;  // throttle expired
        else              wait_q  <= wait_q - 1'b1;
      end
    end
  end

  assign base_o      = base_q;
  assign param_o     = param_q;
  assign throttle_o  = throttle_q;
  assign enable_o    = base_q[0];
  assign busy_o      = busy_q;
  assign req_valid_o = valid_q;
  assign req_addr_o  = addr_q;

  // a waiting request holds, unless software rewrites the base
  a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_valid_o && !req_ready_i && !base_set_i |=> req_valid_o && $stable(req_addr_o))
    else $error("prefetch request changed while waiting for ready");

  a_valid_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_valid_o |-> busy_o)
    else $error("prefetch request outside of a burst");

endmodule

`default_nettype wire

// File: verilog/dcache_req_arbiter.sv
// ================================================
// Fixed-priority valid/ready arbiter onto the data
// cache request port, load first, engines last
// ================================================
`timescale 1ns/10ps
`default_nettype none

module dcache_req_arbiter
  import dcache_front_pkg::*;
(
  input  logic                            load_valid_i,
  input  logic [ADDR_W-1:0]               load_addr_i,
  output logic                            load_ready_o,

  input  logic                            store_valid_i,
  input  logic [ADDR_W-1:0]               store_addr_i,
  output logic                            store_ready_o,

  input  logic [NR_HWPF-1:0]              hwpf_valid_i,
  input  logic [NR_HWPF-1:0][ADDR_W-1:0]  hwpf_addr_i,
  output logic [NR_HWPF-1:0]              hwpf_ready_o,

  output logic                            cache_req_valid_o,
  output logic [ADDR_W-1:0]               cache_req_addr_o,
  output logic [SID_W-1:0]                cache_req_sid_o,
  input  logic                            cache_req_ready_i
);

  logic [NR_REQ-1:0]             req_valid;
  logic [NR_REQ-1:0][ADDR_W-1:0] req_addr;
  logic [NR_REQ-1:0][SID_W-1:0]  req_sid;
  logic [NR_REQ-1:0]             grant;
  logic [NR_REQ-1:0]             ready;

  // index 0 is the highest priority
  assign req_valid = {hwpf_valid_i, store_valid_i, load_valid_i};
  assign req_addr  = {hwpf_addr_i, store_addr_i, load_addr_i};

  assign req_sid[0] = SID_LOAD;
  assign req_sid[1] = SID_STORE;
  for (genvar h = 0; h < NR_HWPF; h++) begin : gen_hwpf_sid
    assign req_sid[2+h] = SID_HWPF0 + SID_W'(h);
  end

  // first valid requester wins
  always_comb begin
    logic found;
    found = 1'b0;
    grant = '0;
    for (int r = 0; r < NR_REQ; r++) begin
      if (req_valid[r] && !found) begin
        grant[r] = 1'b1;
        found    = 1'b1;
      end
    end
  end

  always_comb begin
    cache_req_addr_o = '0;
    cache_req_sid_o  = '0;
    for (int r = 0; r < NR_REQ; r++) begin
      if (grant[r]) begin
        cache_req_addr_o = req_addr[r];
        cache_req_sid_o  = req_sid[r];
      end
    end
  end

  assign cache_req_valid_o = |req_valid;
  assign ready             = grant & {NR_REQ{cache_req_ready_i}};

  assign load_ready_o  = ready[0];
  assign store_ready_o = ready[1];
  assign hwpf_ready_o  = ready[NR_REQ-1:2];

  // no clock here, so checked once the inputs have settled
  always_comb begin
    a_one_ready: assert final ($onehot0(ready))
      else $error("more than one requester sees ready");
  end

endmodule

`default_nettype wire

// File: verilog/dcache_front.sv
// ================================================
// Data-cache front end: core ports, snooping stride
// prefetchers, request arbiter and flush acknowledge
// ================================================
`timescale 1ns/10ps
`default_nettype none

module dcache_front
  import dcache_front_pkg::*;
(
  input  logic                            clk_i,
  input  logic                            rst_ni,

  input  logic                            load_valid_i,
  input  logic [ADDR_W-1:0]               load_addr_i,
  output logic                            load_ready_o,
  input  logic                            store_valid_i,
  input  logic [ADDR_W-1:0]               store_addr_i,
  output logic                            store_ready_o,

  input  logic [NR_HWPF-1:0]              hwpf_base_set_i,
  input  logic [NR_HWPF-1:0]              hwpf_param_set_i,
  input  logic [NR_HWPF-1:0]              hwpf_throttle_set_i,
  input  logic [NR_HWPF-1:0][WORD_W-1:0]  hwpf_base_i,
  input  logic [NR_HWPF-1:0][WORD_W-1:0]  hwpf_param_i,
  input  logic [NR_HWPF-1:0][WORD_W-1:0]  hwpf_throttle_i,
  output logic [NR_HWPF-1:0][WORD_W-1:0]  hwpf_base_o,
  output logic [NR_HWPF-1:0][WORD_W-1:0]  hwpf_param_o,
  output logic [NR_HWPF-1:0][WORD_W-1:0]  hwpf_throttle_o,
  output logic [WORD_W-1:0]               hwpf_status_o,

  output logic                            cache_req_valid_o,
  output logic [ADDR_W-1:0]               cache_req_addr_o,
  output logic [SID_W-1:0]                cache_req_sid_o,
  input  logic                            cache_req_ready_i,

  input  logic                            dcache_flush_i,
  output logic                            dcache_flush_ack_o
);

  logic [NR_SNOOP-1:0]             snoop_valid;
  logic [NR_SNOOP-1:0][ADDR_W-1:0] snoop_addr;

  logic [NR_HWPF-1:0]              hwpf_req_valid;
  logic [NR_HWPF-1:0][ADDR_W-1:0]  hwpf_req_addr;
  logic [NR_HWPF-1:0]              hwpf_req_ready;
  logic [NR_HWPF-1:0]              hwpf_enable;
  logic [NR_HWPF-1:0]              hwpf_busy;
  hwpf_param_u [NR_HWPF-1:0]       hwpf_param_rd;

  // a core access is snooped when its handshake completes
  assign snoop_valid[0] = load_valid_i & load_ready_o;
  assign snoop_addr[0]  = load_addr_i;
  assign snoop_valid[1] = store_valid_i & store_ready_o;
  assign snoop_addr[1]  = store_addr_i;

  for (genvar h = 0; h < NR_HWPF; h++) begin : gen_hwpf
    hwpf_stride_engine hwpf_stride_engine_inst (
      .clk_i          (clk_i),
      .rst_ni         (rst_ni),
      .base_set_i     (hwpf_base_set_i[h]),
      .param_set_i    (hwpf_param_set_i[h]),
      .throttle_set_i (hwpf_throttle_set_i[h]),
      .base_i         (hwpf_base_i[h]),
      .param_i        (hwpf_param_i[h]),
      .throttle_i     (hwpf_throttle_i[h]),
      .base_o         (hwpf_base_o[h]),
      .param_o        (hwpf_param_rd[h]),
      .throttle_o     (hwpf_throttle_o[h]),
      .snoop_valid_i  (snoop_valid),
      .snoop_addr_i   (snoop_addr),
      .enable_o       (hwpf_enable[h]),
      .busy_o         (hwpf_busy[h]),
      .req_valid_o    (hwpf_req_valid[h]),
      .req_addr_o     (hwpf_req_addr[h]),
      .req_ready_i    (hwpf_req_ready[h])
    );

    assign hwpf_param_o[h] = hwpf_param_rd[h].raw;
  end

  dcache_req_arbiter dcache_req_arbiter_inst (
    .load_valid_i      (load_valid_i),
    .load_addr_i       (load_addr_i),
    .load_ready_o      (load_ready_o),
    .store_valid_i     (store_valid_i),
    .store_addr_i      (store_addr_i),
    .store_ready_o     (store_ready_o),
    .hwpf_valid_i      (hwpf_req_valid),
    .hwpf_addr_i       (hwpf_req_addr),
    .hwpf_ready_o      (hwpf_req_ready),
    .cache_req_valid_o (cache_req_valid_o),
    .cache_req_addr_o  (cache_req_addr_o),
    .cache_req_sid_o   (cache_req_sid_o),
    .cache_req_ready_i (cache_req_ready_i)
  );

  always_comb begin
    hwpf_status_o                             = '0;
    hwpf_status_o[NR_HWPF-1:0]                = hwpf_enable;
    hwpf_status_o[STATUS_BUSY_LSB +: NR_HWPF] = hwpf_busy;
  end

  // ack pulses every other cycle while flush is held
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) dcache_flush_ack_o <= 1'b0;
    else         dcache_flush_ack_o <= ~dcache_flush_ack_o & dcache_flush_i;
  end

endmodule

`default_nettype wire

// File: sim/dcache_front_checker.sv
// ================================================
// Testbench checker: predicts arbitration, engine
// bursts, readback, status and flush acknowledge
// ================================================
`timescale 1ns/10ps
`default_nettype none

module dcache_front_checker
  import dcache_front_pkg::*;
(
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           load_valid_i,
  input  logic [ADDR_W-1:0]              load_addr_i,
  input  logic                           load_ready_i,
  input  logic                           store_valid_i,
  input  logic [ADDR_W-1:0]              store_addr_i,
  input  logic                           store_ready_i,
  input  logic [NR_HWPF-1:0]             base_set_i,
  input  logic [NR_HWPF-1:0]             param_set_i,
  input  logic [NR_HWPF-1:0]             throttle_set_i,
  input  logic [NR_HWPF-1:0][WORD_W-1:0] base_wr_i,
  input  logic [NR_HWPF-1:0][WORD_W-1:0] param_wr_i,
  input  logic [NR_HWPF-1:0][WORD_W-1:0] throttle_wr_i,
  input  logic [NR_HWPF-1:0][WORD_W-1:0] base_rd_i,
  input  logic [NR_HWPF-1:0][WORD_W-1:0] param_rd_i,
  input  logic [NR_HWPF-1:0][WORD_W-1:0] throttle_rd_i,
  input  logic [WORD_W-1:0]              status_i,
  input  logic                           cache_valid_i,
  input  logic [ADDR_W-1:0]              cache_addr_i,
  input  logic [SID_W-1:0]               cache_sid_i,
  input  logic                           cache_ready_i,
  input  logic                           flush_i,
  input  logic                           flush_ack_i,
  output int                             error_count_o,
  output int                             burst_count_o
);

  // engine model state, as seen after the last edge
  logic [WORD_W-1:0] m_base     [NR_HWPF];
  logic [WORD_W-1:0] m_param    [NR_HWPF];
  logic [WORD_W-1:0] m_throttle [NR_HWPF];
  logic              m_busy     [NR_HWPF];
  logic              m_valid    [NR_HWPF];
  logic [ADDR_W-1:0] m_addr     [NR_HWPF];
  int                m_left     [NR_HWPF];  // acceptances still due
  longint            m_rise     [NR_HWPF];  // edge at which valid comes back
  longint            edge_count;
  logic              m_ack;

  // lowest index wins, NR_REQ when nobody asks
  function automatic int arb_winner(input logic [NR_REQ-1:0] valid);
    int win;
    win = NR_REQ;
    for (int r = NR_REQ - 1; r >= 0; r--) begin
      if (valid[r]) win = r;
    end
    return win;
  endfunction

  function automatic logic [SID_W-1:0] sid_of(input int r);
    if (r == 0) return SID_LOAD;
    if (r == 1) return SID_STORE;
    return SID_HWPF0 + SID_W'(r - 2);
  endfunction

  task automatic check_word(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("ERROR t=%0t %s: expected %h, got %h", $time, name, exp, got);
      error_count_o++;
    end
  endtask

  always @(posedge clk_i) begin : compare
    logic [NR_REQ-1:0]             req_valid;
    logic [NR_REQ-1:0][ADDR_W-1:0] req_addr;
    logic [WORD_W-1:0]             exp_status;
    logic [ADDR_W-1:0]             stride;
    logic [NLINES_W-1:0]           nlines;
    hwpf_param_u                   pv;
    int                            win;
    logic                          ld_acc;
    logic                          st_acc;
    logic                          hit;
    logic                          pf_acc;

    if (!rst_ni) begin
      for (int h = 0; h < NR_HWPF; h++) begin
        m_base[h]     = '0;
        m_param[h]    = '0;
        m_throttle[h] = '0;
        m_busy[h]     = 1'b0;
        m_valid[h]    = 1'b0;
        m_addr[h]     = '0;
        m_left[h]     = 0;
        m_rise[h]     = 0;
      end
      edge_count    = 0;
      m_ack         = 1'b0;
      error_count_o = 0;
      burst_count_o = 0;
    end else begin
      req_valid[0] = load_valid_i;
      req_addr[0]  = load_addr_i;
      req_valid[1] = store_valid_i;
      req_addr[1]  = store_addr_i;
      for (int h = 0; h < NR_HWPF; h++) begin
        req_valid[2+h] = m_valid[h];
        req_addr[2+h]  = m_addr[h];
      end
      win = arb_winner(req_valid);

      check_word("cache_req_valid_o", 64'(cache_valid_i), 64'(win < NR_REQ));
      if (win < NR_REQ) begin
        check_word("cache_req_addr_o", cache_addr_i, req_addr[win]);
        check_word("cache_req_sid_o", 64'(cache_sid_i), 64'(sid_of(win)));
      end
      check_word("load_ready_o", 64'(load_ready_i), 64'(win == 0 && cache_ready_i));
      check_word("store_ready_o", 64'(store_ready_i), 64'(win == 1 && cache_ready_i));

      exp_status = '0;
      for (int h = 0; h < NR_HWPF; h++) begin
        check_word($sformatf("hwpf_base_o[%0d]", h), base_rd_i[h], m_base[h]);
        check_word($sformatf("hwpf_param_o[%0d]", h), param_rd_i[h], m_param[h]);
        check_word($sformatf("hwpf_throttle_o[%0d]", h), throttle_rd_i[h], m_throttle[h]);
        pv.raw = param_rd_i[h];  // same word, field view
        check_word($sformatf("hwpf_param_o[%0d] stride", h), 64'(pv.f.stride),
                   64'(m_param[h][STRIDE_W-1:0]));
        check_word($sformatf("hwpf_param_o[%0d] nlines", h), 64'(pv.f.nlines),
                   64'(m_param[h][STRIDE_W +: NLINES_W]));
        exp_status[h]                   = m_base[h][0];
        exp_status[STATUS_BUSY_LSB + h] = m_busy[h];
      end
      check_word("hwpf_status_o", status_i, exp_status);
      check_word("dcache_flush_ack_o", 64'(flush_ack_i), 64'(m_ack));

      // step the model through this edge
      ld_acc = load_valid_i && win == 0 && cache_ready_i;
      st_acc = store_valid_i && win == 1 && cache_ready_i;
      for (int h = 0; h < NR_HWPF; h++) begin
        hit = (ld_acc && load_addr_i[ADDR_W-1:LINE_OFS_W] == m_base[h][WORD_W-1:LINE_OFS_W]) ||
              (st_acc && store_addr_i[ADDR_W-1:LINE_OFS_W] == m_base[h][WORD_W-1:LINE_OFS_W]);
        pf_acc = m_valid[h] && win == 2 + h && cache_ready_i;
        nlines = m_param[h][STRIDE_W +: NLINES_W];
        stride = ADDR_W'(m_param[h][STRIDE_W-1:0]);
        if (base_set_i[h]) begin
          m_base[h]  = base_wr_i[h];  // also cancels a burst
          m_busy[h]  = 1'b0;
          m_valid[h] = 1'b0;
        end else if (m_base[h][0] && !m_busy[h] && nlines != '0 && hit) begin
          m_busy[h]  = 1'b1;
          m_valid[h] = 1'b1;
          m_addr[h]  = {m_base[h][WORD_W-1:LINE_OFS_W], {LINE_OFS_W{1'b0}}} + stride;
          m_left[h]  = int'(nlines);
        end else if (pf_acc) begin
          m_valid[h] = 1'b0;
          m_left[h]  = m_left[h] - 1;
          if (m_left[h] == 0) begin
            m_base[h] = {m_addr[h][ADDR_W-1:LINE_OFS_W], m_base[h][LINE_OFS_W-1:0]};
            m_busy[h] = 1'b0;
            burst_count_o++;
          end else begin
            m_addr[h] = m_addr[h] + stride;
            m_rise[h] = edge_count + longint'(m_throttle[h][NWAIT_W-1:0]) + 1;
          end
        end else if (m_busy[h] && !m_valid[h] && edge_count == m_rise[h]) begin
          m_valid[h] = 1'b1;
        end
        if (param_set_i[h]) m_param[h] = param_wr_i[h];
        if (throttle_set_i[h]) m_throttle[h] = throttle_wr_i[h];
      end
      m_ack      = !m_ack && flush_i;
      edge_count = edge_count + 1;
    end
  end

endmodule

`default_nettype wire

// File: sim/tb_dcache_front.sv
// ================================================
// Testbench for the data-cache front end with clock,
// reset, stimulus, cache ready model and watchdog
// ================================================
`timescale 1ns/10ps
`default_nettype none

module tb_dcache_front
  import dcache_front_pkg::*;
();

  localparam int     CLK_PERIOD    = 100;
  localparam int     RESET_CYCLES  = 3;
  localparam int     BURST_ROUNDS  = 24;
  localparam int     ROUND_BOUND   = 64;   // generous cycles per burst round
  localparam int     RAND_CYCLES   = 400;
  localparam int     CONFIG_CYCLES = 2 * 3 * NR_HWPF;
  localparam int     STIM_CYCLES   = RESET_CYCLES + CONFIG_CYCLES + BURST_ROUNDS * ROUND_BOUND +
                                     RAND_CYCLES + ROUND_BOUND + 16;
  localparam int     MARGIN_CYCLES = 500;
  localparam longint WATCHDOG_NS   = longint'(STIM_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;

  logic clk_i  = 1'b0;
  logic rst_ni = 1'b0;

  logic                           load_valid   = 1'b0;
  logic [ADDR_W-1:0]              load_addr    = '0;
  logic                           load_ready;
  logic                           store_valid  = 1'b0;
  logic [ADDR_W-1:0]              store_addr   = '0;
  logic                           store_ready;
  logic [NR_HWPF-1:0]             base_set     = '0;
  logic [NR_HWPF-1:0]             param_set    = '0;
  logic [NR_HWPF-1:0]             throttle_set = '0;
  logic [NR_HWPF-1:0][WORD_W-1:0] base_wr      = '0;
  logic [NR_HWPF-1:0][WORD_W-1:0] param_wr     = '0;
  logic [NR_HWPF-1:0][WORD_W-1:0] throttle_wr  = '0;
  logic [NR_HWPF-1:0][WORD_W-1:0] base_rd;
  logic [NR_HWPF-1:0][WORD_W-1:0] param_rd;
  logic [NR_HWPF-1:0][WORD_W-1:0] throttle_rd;
  logic [WORD_W-1:0]              status;
  logic                           cache_valid;
  logic [ADDR_W-1:0]              cache_addr;
  logic [SID_W-1:0]               cache_sid;
  logic                           cache_ready  = 1'b0;
  logic                           flush        = 1'b0;
  logic                           flush_ack;

  logic        random_ready = 1'b0;  // cache stalls at random when set
  int          error_count;
  int          burst_count;

  dcache_front dcache_front_inst (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .load_valid_i (load_valid), .load_addr_i (load_addr), .load_ready_o (load_ready),
    .store_valid_i (store_valid), .store_addr_i (store_addr), .store_ready_o (store_ready),
    .hwpf_base_set_i (base_set), .hwpf_param_set_i (param_set),
    .hwpf_throttle_set_i (throttle_set),
    .hwpf_base_i (base_wr), .hwpf_param_i (param_wr), .hwpf_throttle_i (throttle_wr),
    .hwpf_base_o (base_rd), .hwpf_param_o (param_rd), .hwpf_throttle_o (throttle_rd),
    .hwpf_status_o (status),
    .cache_req_valid_o (cache_valid), .cache_req_addr_o (cache_addr),
    .cache_req_sid_o (cache_sid), .cache_req_ready_i (cache_ready),
    .dcache_flush_i (flush), .dcache_flush_ack_o (flush_ack)
  );

  dcache_front_checker dcache_front_checker_inst (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .load_valid_i (load_valid), .load_addr_i (load_addr), .load_ready_i (load_ready),
    .store_valid_i (store_valid), .store_addr_i (store_addr), .store_ready_i (store_ready),
    .base_set_i (base_set), .param_set_i (param_set), .throttle_set_i (throttle_set),
    .base_wr_i (base_wr), .param_wr_i (param_wr), .throttle_wr_i (throttle_wr),
    .base_rd_i (base_rd), .param_rd_i (param_rd), .throttle_rd_i (throttle_rd),
    .status_i (status),
    .cache_valid_i (cache_valid), .cache_addr_i (cache_addr), .cache_sid_i (cache_sid),
    .cache_ready_i (cache_ready), .flush_i (flush), .flush_ack_i (flush_ack),
    .error_count_o (error_count), .burst_count_o (burst_count)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // cache side of the request handshake
  always @(negedge clk_i) begin
    if (random_ready) cache_ready = 1'($urandom % 2);
    else              cache_ready = 1'b1;
  end

  task automatic program_engine(input int h, input logic en, input logic [NLINES_W-1:0] nlines);
    logic [STRIDE_W-1:0] stride;
    stride = STRIDE_W'((($urandom % 4) + 1) * 64);
    @(negedge clk_i);
    base_wr[h]     = {$urandom, $urandom};
    base_wr[h][0]  = en;
    param_wr[h]    = {16'($urandom), nlines, stride};
    throttle_wr[h] = {$urandom, 16'($urandom), 16'($urandom % 4)};  // nwait 0..3
    base_set[h]     = 1'b1;
    param_set[h]    = 1'b1;
    throttle_set[h] = 1'b1;
    @(negedge clk_i);
    base_set     = '0;
    param_set    = '0;
    throttle_set = '0;
  endtask

  // one load or store held until the cache takes it
  task automatic core_access(input logic is_store, input logic [ADDR_W-1:0] addr);
    @(negedge clk_i);
    if (is_store) begin
      store_valid = 1'b1;
      store_addr  = addr;
    end else begin
      load_valid = 1'b1;
      load_addr  = addr;
    end
    @(posedge clk_i);
    while (!(is_store ? store_ready : load_ready)) @(posedge clk_i);
    @(negedge clk_i);
    load_valid  = 1'b0;
    store_valid = 1'b0;
  endtask

  task automatic wait_idle();
    @(negedge clk_i);
    while (status[STATUS_BUSY_LSB +: NR_HWPF] != '0) @(negedge clk_i);
  endtask

  // a quarter of the addresses land on some engine's base line
  function automatic logic [ADDR_W-1:0] pick_addr();
    int h;
    h = int'($urandom % NR_HWPF);
    if ($urandom % 4 == 0) return {base_rd[h][ADDR_W-1:LINE_OFS_W], LINE_OFS_W'($urandom)};
    return {$urandom, $urandom};
  endfunction

  task automatic random_traffic(input int cycles);
    logic ld_done;
    logic st_done;
    random_ready = 1'b1;
    for (int i = 0; i < cycles || load_valid || store_valid; i++) begin
      @(posedge clk_i);
      ld_done = load_valid && load_ready;
      st_done = store_valid && store_ready;
      @(negedge clk_i);
      if (ld_done) load_valid = 1'b0;
      if (st_done) store_valid = 1'b0;
      if (i < cycles && !load_valid) begin
        load_valid = 1'($urandom % 2);
        load_addr  = pick_addr();
      end
      if (i < cycles && !store_valid) begin
        store_valid = 1'($urandom % 2);
        store_addr  = pick_addr();
      end
    end
  endtask

  initial begin : stimulus
    int                h;
    logic [ADDR_W-1:0] addr;
    void'($urandom(32'h4d9a_597b));
    repeat (RESET_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    // engine 2 gets an empty burst and engine 3 stays disabled
    program_engine(0, 1'b1, NLINES_W'(($urandom % 4) + 1));
    program_engine(1, 1'b1, NLINES_W'(($urandom % 4) + 1));
    program_engine(2, 1'b1, '0);
    program_engine(3, 1'b0, NLINES_W'(3));

    for (int r = 0; r < BURST_ROUNDS; r++) begin
      if (r == BURST_ROUNDS / 2) begin
        for (int e = 0; e < NR_HWPF; e++) program_engine(e, 1'b1, NLINES_W'(($urandom % 4) + 1));
      end
      if (r == 3 * BURST_ROUNDS / 4) program_engine(0, 1'b0, NLINES_W'(2));
      random_ready = (r % 2) == 1;  // even rounds see a cache that never stalls
      h = int'($urandom % NR_HWPF);
      if (r % 5 == 4) addr = {$urandom, $urandom};  // almost surely a miss
      else            addr = {base_rd[h][ADDR_W-1:LINE_OFS_W], LINE_OFS_W'($urandom)};
      core_access(1'($urandom % 2), addr);
      wait_idle();
    end

    random_traffic(RAND_CYCLES);
    wait_idle();

    // hold flush for a while, then let it drop
    random_ready = 1'b0;
    @(negedge clk_i);
    flush = 1'b1;
    repeat (7) @(negedge clk_i);
    flush = 1'b0;
    repeat (4) @(negedge clk_i);

    $display("checks finished: %0d errors, %0d prefetch bursts completed",
             error_count, burst_count);
    if (error_count == 0 && burst_count > 0) begin
      $display("TESTS PASSED");
    end else begin
      if (burst_count == 0) $display("no prefetch burst completed during the run");
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d cycles, stimulus did not finish",
             STIM_CYCLES + MARGIN_CYCLES);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
verilog/dcache_front_pkg.sv
verilog/hwpf_stride_engine.sv
verilog/dcache_req_arbiter.sv
verilog/dcache_front.sv
sim/dcache_front_checker.sv
sim/tb_dcache_front.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the data-cache front-end testbench with Verilator and run it.
# Exits non-zero when the log shows a failing run.
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -Wno-fatal \
  -f src.f --top-module tb_dcache_front \
  --Mdir obj_dir -o tb_dcache_front

./obj_dir/tb_dcache_front | tee "$LOG"

if grep -q "TESTS FAILED" "$LOG"; then
  echo "simulation reported a failure, see $LOG"
  exit 1
fi
if ! grep -q "TESTS PASSED" "$LOG"; then
  echo "simulation ended without a result line, see $LOG"
  exit 1
fi
echo "simulation finished cleanly"
